/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f filelist.f --top-module tb_mmu -o sim_mmu

run: compile
	./obj_dir/sim_mmu | awk '{ print } /^TEST PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

/* filelist.f */
+incdir+src
src/mmu_pkg.sv
src/page_table_walker.sv
src/tlb.sv
src/translation_control.sv
src/mmu_top.sv
verif/page_memory_model.sv
verif/tb_mmu.sv

/* src/mmu_config.svh */
/* Build-time settings of the Sv32 translation unit: PTE flag positions and widths.
   Included by the package and by every module that decodes PTEs or sizes ports. */
`ifndef MMU_CONFIG_SVH
`define MMU_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PTE flag bit numbers.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define MMU_PTE_V 0
`define MMU_PTE_R 1
`define MMU_PTE_W 2
`define MMU_PTE_X 3
`define MMU_PTE_A 6
`define MMU_PTE_D 7

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizes.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define MMU_TLB_INDEX_BITS 3
`define MMU_VPN_BITS 20
`define MMU_PPN_BITS 22
`define MMU_PADDR_BITS 34

`endif

/* src/mmu_pkg.sv */
/* Shared enums and packed structs of the translation unit.
   Modules refer to these by scoped names. */
`default_nettype none

`include "mmu_config.svh"

package mmu_pkg;

    typedef enum logic [1:0] {
        ACCESS_LOAD    = 2'd0,
        ACCESS_STORE   = 2'd1,
        ACCESS_EXECUTE = 2'd2
    } access_e;

    typedef enum logic [2:0] {
        BUS_OKAY         = 3'd0,
        BUS_SLAVE_ERROR  = 3'd1,
        BUS_DECODE_ERROR = 3'd2
    } bus_resp_e;

    typedef enum logic {
        PTW_IDLE = 1'b0,
        PTW_WALK = 1'b1
    } ptw_state_e;

    typedef enum logic [1:0] {
        CTL_IDLE    = 2'd0,
        CTL_LOOKUP  = 2'd1,
        CTL_WALK    = 2'd2,
        CTL_RESPOND = 2'd3
    } ctl_state_e;

    // Read-only bus, held until done.
    typedef struct packed {
        logic                        transaction;
        logic [`MMU_PADDR_BITS-1:0]  address;
    } bus_req_t;

    typedef struct packed {
        logic        done;
        bus_resp_e   response;
        logic [31:0] rdata;
    } bus_rsp_t;

    typedef struct packed {
        logic                      request;
        logic [`MMU_VPN_BITS-1:0]  vpn;
        access_e                   access;
    } translate_req_t;

    typedef struct packed {
        logic                      done;
        logic                      pagefault;
        logic                      accessfault;
        logic [`MMU_PPN_BITS-1:0]  ppn;
    } translate_rsp_t;

    // Result of a translation as held in the TLB.
    typedef struct packed {
        logic [`MMU_PPN_BITS-1:0]  ppn;
        logic [7:0]                access_bits;
    } leaf_t;

endpackage

`default_nettype wire

/* src/mmu_top.sv */
/* Top of the Sv32 translation unit. Wires the sequencer,
   the TLB and the page table walker to the outside ports. */
`timescale 1ns/100ps
`default_nettype none

`include "mmu_config.svh"

module mmu_top (
    input  wire                          clk,
    input  wire                          rst_n,
    input  mmu_pkg::translate_req_t      req,
    output logic                         ack,
    output mmu_pkg::translate_rsp_t      rsp,
    output mmu_pkg::bus_req_t            bus_req,
    input  mmu_pkg::bus_rsp_t            bus_rsp,
    input  wire                          satp_mode,
    input  wire [`MMU_PPN_BITS-1:0]      satp_ppn,
    input  wire                          flush
);

    logic [`MMU_VPN_BITS-1:0] lookup_vpn;
    logic [`MMU_VPN_BITS-1:0] fill_vpn;
    logic                     tlb_hit;
    logic                     fill;
    logic                     walk_start;
    logic                     walk_done;
    logic                     walk_pagefault;
    logic                     walk_accessfault;
    mmu_pkg::leaf_t           tlb_leaf;
    mmu_pkg::leaf_t           walk_leaf;
    mmu_pkg::leaf_t           fill_leaf;

    translation_control i_control (
        .clk              (clk),
        .rst_n            (rst_n),
        .req              (req),
        .satp_mode        (satp_mode),
        .tlb_hit          (tlb_hit),
        .tlb_leaf         (tlb_leaf),
        .walk_done        (walk_done),
        .walk_pagefault   (walk_pagefault),
        .walk_accessfault (walk_accessfault),
        .walk_leaf        (walk_leaf),
        .ack              (ack),
        .rsp              (rsp),
        .lookup_vpn       (lookup_vpn),
        .walk_start       (walk_start),
        .fill             (fill),
        .fill_vpn         (fill_vpn),
        .fill_leaf        (fill_leaf)
    );

    tlb i_tlb (
        .clk        (clk),
        .rst_n      (rst_n),
        .lookup_vpn (lookup_vpn),
        .fill       (fill),
        .fill_vpn   (fill_vpn),
        .fill_leaf  (fill_leaf),
        .flush      (flush),
        .hit        (tlb_hit),
        .hit_leaf   (tlb_leaf)
    );

    // The walker translates the same registered vpn the TLB just missed on.
    page_table_walker i_walker (
        .clk         (clk),
        .rst_n       (rst_n),
        .walk_start  (walk_start),
        .vpn         (lookup_vpn),
        .root_ppn    (satp_ppn),
        .bus_rsp     (bus_rsp),
        .bus_req     (bus_req),
        .walk_done   (walk_done),
        .pagefault   (walk_pagefault),
        .accessfault (walk_accessfault),
        .leaf        (walk_leaf)
    );

endmodule

`default_nettype wire

/* src/page_table_walker.sv */
/* Two-level Sv32 page table walker. Reads PTEs over the bus from root_ppn
   and reports the leaf or a fault in the cycle of the final bus done. */
`timescale 1ns/100ps
`default_nettype none

`include "mmu_config.svh"

module page_table_walker (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          walk_start,
    input  wire [`MMU_VPN_BITS-1:0]      vpn,
    input  wire [`MMU_PPN_BITS-1:0]      root_ppn,
    input  mmu_pkg::bus_rsp_t            bus_rsp,
    output mmu_pkg::bus_req_t            bus_req,
    output logic                         walk_done,
    output logic                         pagefault,
    output logic                         accessfault,
    output mmu_pkg::leaf_t               leaf
);

    mmu_pkg::ptw_state_e state;

    logic                      level;         // 1 while reading the root table.
    logic [`MMU_PPN_BITS-1:0]  table_base;
    logic [`MMU_VPN_BITS-1:0]  saved_vpn;

    logic [9:0] vpn_field;
    logic [9:0] pte_ppn0;
    logic [11:0] pte_ppn1;

    logic bus_error;
    logic pte_invalid;
    logic pte_leaf;
    logic pte_misaligned;
    logic pte_done;
    logic descend;

    assign vpn_field = level ? saved_vpn[19:10] : saved_vpn[9:0];

    assign bus_req.transaction = (state == mmu_pkg::PTW_WALK);
    assign bus_req.address     = {table_base, vpn_field, 2'b00};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // PTE decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign pte_ppn0 = bus_rsp.rdata[19:10];
    assign pte_ppn1 = bus_rsp.rdata[31:20];

    assign bus_error   = (bus_rsp.response != mmu_pkg::BUS_OKAY);
    assign pte_invalid = !bus_rsp.rdata[`MMU_PTE_V] ||
                         (bus_rsp.rdata[`MMU_PTE_W] && !bus_rsp.rdata[`MMU_PTE_R]);
    assign pte_leaf    = bus_rsp.rdata[`MMU_PTE_R] || bus_rsp.rdata[`MMU_PTE_X];
    assign pte_misaligned = level && (pte_ppn0 != 10'd0);  // Megapage must be 4 MiB aligned.

    assign pte_done = (state == mmu_pkg::PTW_WALK) && bus_rsp.done;
    assign descend  = pte_done && !bus_error && !pte_invalid && !pte_leaf && level;

    // A megapage maps the low vpn field straight through.
    assign leaf.ppn         = level ? {pte_ppn1, saved_vpn[9:0]} : {pte_ppn1, pte_ppn0};
    assign leaf.access_bits = bus_rsp.rdata[7:0];

    always_comb begin
        walk_done   = 1'b0;
        pagefault   = 1'b0;
        accessfault = 1'b0;
        if (pte_done && !descend) begin
            walk_done = 1'b1;
            if (bus_error) begin
                accessfault = 1'b1;
            end else if (pte_invalid) begin
                pagefault = 1'b1;
            end else if (pte_leaf) begin
                pagefault = pte_misaligned;
            end else begin
                pagefault = 1'b1;  // Pointer found where a leaf was required.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= mmu_pkg::PTW_IDLE;
        end else begin
            case (state)
                mmu_pkg::PTW_IDLE: begin
                    if (walk_start) begin
                        state <= mmu_pkg::PTW_WALK;
                    end
                end
                mmu_pkg::PTW_WALK: begin
                    if (walk_done) begin
                        state <= mmu_pkg::PTW_IDLE;
                    end
                end
                default: state <= mmu_pkg::PTW_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mmu_pkg::PTW_IDLE && walk_start) begin
            level      <= 1'b1;
            table_base <= root_ppn;
            saved_vpn  <= vpn;
        end else if (descend) begin
            level      <= 1'b0;
            table_base <= bus_rsp.rdata[31:10];  // Next table comes from the pointer PTE.
        end
    end

    // The bus must see one steady address for the whole read.
    bus_addr_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (bus_req.transaction && !bus_rsp.done) |=>
            (bus_req.transaction && $stable(bus_req.address))
    );

endmodule

`default_nettype wire

/* src/tlb.sv */
/* Direct-mapped TLB holding walk results. Lookup is combinational,
   fill writes one entry and flush invalidates all of them. */
`timescale 1ns/100ps
`default_nettype none

`include "mmu_config.svh"

module tlb (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire [`MMU_VPN_BITS-1:0]      lookup_vpn,
    input  wire                          fill,
    input  wire [`MMU_VPN_BITS-1:0]      fill_vpn,
    input  mmu_pkg::leaf_t               fill_leaf,
    input  wire                          flush,
    output logic                         hit,
    output mmu_pkg::leaf_t               hit_leaf
);

    localparam int ENTRIES  = 1 << `MMU_TLB_INDEX_BITS;
    localparam int TAG_BITS = `MMU_VPN_BITS - `MMU_TLB_INDEX_BITS;

    logic [ENTRIES-1:0]  valid;
    logic [TAG_BITS-1:0] tag_mem  [ENTRIES];
    mmu_pkg::leaf_t      leaf_mem [ENTRIES];

    logic [`MMU_TLB_INDEX_BITS-1:0] lookup_idx;
    logic [`MMU_TLB_INDEX_BITS-1:0] fill_idx;
    logic [TAG_BITS-1:0]            lookup_tag;
    logic [TAG_BITS-1:0]            fill_tag;

    assign lookup_idx = lookup_vpn[`MMU_TLB_INDEX_BITS-1:0];
    assign lookup_tag = lookup_vpn[`MMU_VPN_BITS-1:`MMU_TLB_INDEX_BITS];
    assign fill_idx   = fill_vpn[`MMU_TLB_INDEX_BITS-1:0];
    assign fill_tag   = fill_vpn[`MMU_VPN_BITS-1:`MMU_TLB_INDEX_BITS];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lookup
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign hit      = valid[lookup_idx] && (tag_mem[lookup_idx] == lookup_tag);
    assign hit_leaf = leaf_mem[lookup_idx];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Update
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (flush) begin
            valid <= '0;  // Flush takes priority over a fill.
        end else if (fill) begin
            valid[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill && !flush) begin
            tag_mem[fill_idx]  <= fill_tag;
            leaf_mem[fill_idx] <= fill_leaf;
        end
    end

    // Flush is only issued while idle, and fills happen only at the end of a walk.
    fill_flush_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(fill && flush)
    );

endmodule

`default_nettype wire

/* src/translation_control.sv */
/* Request sequencer: picks the bare, TLB or walk path, applies the
   permission check to the leaf and drives the response and TLB fill. */
`timescale 1ns/100ps
`default_nettype none

`include "mmu_config.svh"

module translation_control (
    input  wire                          clk,
    input  wire                          rst_n,
    input  mmu_pkg::translate_req_t      req,
    input  wire                          satp_mode,
    input  wire                          tlb_hit,
    input  mmu_pkg::leaf_t               tlb_leaf,
    input  wire                          walk_done,
    input  wire                          walk_pagefault,
    input  wire                          walk_accessfault,
    input  mmu_pkg::leaf_t               walk_leaf,
    output logic                         ack,
    output mmu_pkg::translate_rsp_t      rsp,
    output logic [`MMU_VPN_BITS-1:0]     lookup_vpn,
    output logic                         walk_start,
    output logic                         fill,
    output logic [`MMU_VPN_BITS-1:0]     fill_vpn,
    output mmu_pkg::leaf_t               fill_leaf
);

    mmu_pkg::ctl_state_e state;

    logic [`MMU_VPN_BITS-1:0]  req_vpn;
    mmu_pkg::access_e          req_access;
    logic [`MMU_PPN_BITS-1:0]  res_ppn;
    logic                      res_pagefault;
    logic                      res_accessfault;

    logic walk_fault;
    logic walk_perm_fault;
    logic hit_perm_fault;

    // Access type against the leaf's R, W, X, A and D bits.
    function automatic logic perm_ok(input logic [7:0] bits, input mmu_pkg::access_e access);
        logic kind_ok;
        case (access)
            mmu_pkg::ACCESS_LOAD:    kind_ok = bits[`MMU_PTE_R];
            mmu_pkg::ACCESS_STORE:   kind_ok = bits[`MMU_PTE_W] && bits[`MMU_PTE_D];
            mmu_pkg::ACCESS_EXECUTE: kind_ok = bits[`MMU_PTE_X];
            default:                 kind_ok = 1'b0;
        endcase
        return kind_ok && bits[`MMU_PTE_A];
    endfunction

    assign walk_fault      = walk_pagefault || walk_accessfault;
    assign walk_perm_fault = !walk_fault && !perm_ok(walk_leaf.access_bits, req_access);
    assign hit_perm_fault  = !perm_ok(tlb_leaf.access_bits, req_access);

    assign ack        = (state == mmu_pkg::CTL_IDLE);
    assign lookup_vpn = req_vpn;
    assign walk_start = (state == mmu_pkg::CTL_LOOKUP) && !tlb_hit;

    assign fill      = (state == mmu_pkg::CTL_WALK) && walk_done && !walk_fault;
    assign fill_vpn  = req_vpn;
    assign fill_leaf = walk_leaf;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Response
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        rsp.done        = (state == mmu_pkg::CTL_RESPOND);
        rsp.pagefault   = res_pagefault;
        rsp.accessfault = res_accessfault;
        rsp.ppn         = res_ppn;
        if (state == mmu_pkg::CTL_LOOKUP) begin
            // A hit answers straight from the TLB in this cycle.
            rsp.done        = tlb_hit;
            rsp.pagefault   = hit_perm_fault;
            rsp.accessfault = 1'b0;
            rsp.ppn         = hit_perm_fault ? '0 : tlb_leaf.ppn;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= mmu_pkg::CTL_IDLE;
        end else begin
            case (state)
                mmu_pkg::CTL_IDLE: begin
                    if (req.request) begin
                        state <= satp_mode ? mmu_pkg::CTL_LOOKUP : mmu_pkg::CTL_RESPOND;
                    end
                end
                mmu_pkg::CTL_LOOKUP: begin
                    state <= tlb_hit ? mmu_pkg::CTL_IDLE : mmu_pkg::CTL_WALK;
                end
                mmu_pkg::CTL_WALK: begin
                    if (walk_done) begin
                        state <= mmu_pkg::CTL_RESPOND;
                    end
                end
                default: state <= mmu_pkg::CTL_IDLE;  // CTL_RESPOND lasts one cycle.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mmu_pkg::CTL_IDLE && req.request) begin
            req_vpn         <= req.vpn;
            req_access      <= req.access;
            res_ppn         <= {{(`MMU_PPN_BITS - `MMU_VPN_BITS){1'b0}}, req.vpn};  // Bare mode.
            res_pagefault   <= 1'b0;
            res_accessfault <= 1'b0;
        end else if (state == mmu_pkg::CTL_WALK && walk_done) begin
            res_pagefault   <= walk_pagefault || walk_perm_fault;
            res_accessfault <= walk_accessfault;
            res_ppn         <= (walk_fault || walk_perm_fault) ? '0 : walk_leaf.ppn;
        end
    end

    // Every path returns to idle after its done cycle.
    single_done_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp.done |=> !rsp.done
    );

endmodule

`default_nettype wire

/* verif/page_memory_model.sv */
/* Testbench memory behind the walker's read bus. Each read is answered after
   0 to 3 random wait cycles, and one page answers with a slave error. */
`timescale 1ns/100ps
`default_nettype none

`include "mmu_config.svh"

module page_memory_model #(
    parameter int unsigned                 SEED      = 48,
    parameter logic [`MMU_PPN_BITS-1:0]    ERROR_PPN = 22'h0000EE
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  mmu_pkg::bus_req_t    bus_req,
    output mmu_pkg::bus_rsp_t    bus_rsp
);

    logic [31:0] words [logic [31:0]];  // Keyed by word address, unwritten words read as zero.

    task automatic write_word(input logic [`MMU_PADDR_BITS-1:0] address,
                              input logic [31:0] data);
        words[address[`MMU_PADDR_BITS-1:2]] = data;
    endtask

    function automatic mmu_pkg::bus_rsp_t read_reply(input logic [`MMU_PADDR_BITS-1:0] address);
        mmu_pkg::bus_rsp_t reply;
        reply.done     = 1'b1;
        reply.response = mmu_pkg::BUS_OKAY;
        reply.rdata    = '0;
        if (address[`MMU_PADDR_BITS-1:12] == ERROR_PPN) begin
            reply.response = mmu_pkg::BUS_SLAVE_ERROR;
        end else if (words.exists(address[`MMU_PADDR_BITS-1:2])) begin
            reply.rdata = words[address[`MMU_PADDR_BITS-1:2]];
        end
        return reply;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read responder
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int unsigned wait_left;
        logic        busy;
        bus_rsp   = '0;
        wait_left = 0;
        busy      = 1'b0;
        void'($urandom(SEED));
        forever begin
            @(posedge clk);
            #2;
            if (!rst_n || !bus_req.transaction) begin
                bus_rsp = '0;
                busy    = 1'b0;
            end else begin
                if (!busy) begin
                    wait_left = $urandom_range(3, 0);  // A new read starts here.
                    busy      = 1'b1;
                end
                if (wait_left == 0) begin
                    bus_rsp = read_reply(bus_req.address);
                    busy    = 1'b0;
                end else begin
                    bus_rsp   = '0;
                    wait_left = wait_left - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verif/tb_mmu.sv */
/* Testbench for the Sv32 translation unit. Builds page tables in the memory
   model and runs a table of requests, checking result, faults and bus reads. */
`timescale 1ns/100ps
`default_nettype none

`include "mmu_config.svh"

module tb_mmu;

    typedef struct packed {
        logic                      mode;
        logic [`MMU_VPN_BITS-1:0]  vpn;
        mmu_pkg::access_e          access;
        logic                      flush;
        logic [`MMU_PPN_BITS-1:0]  ppn;
        logic                      pf;
        logic                      af;
        logic [1:0]                reads;
    } row_t;

    localparam int NUM_ROWS     = 29;
    localparam int ACK_TIMEOUT  = 20;
    localparam int DONE_TIMEOUT = 50;

    localparam logic [`MMU_PPN_BITS-1:0] ROOT_PPN  = 22'h000100;
    localparam logic [`MMU_PPN_BITS-1:0] ERROR_PPN = 22'h0000EE;

    localparam logic [7:0] F_V = 8'h01;
    localparam logic [7:0] F_R = 8'h02;
    localparam logic [7:0] F_W = 8'h04;
    localparam logic [7:0] F_X = 8'h08;
    localparam logic [7:0] F_A = 8'h40;
    localparam logic [7:0] F_D = 8'h80;

    localparam mmu_pkg::access_e LD = mmu_pkg::ACCESS_LOAD;
    localparam mmu_pkg::access_e ST = mmu_pkg::ACCESS_STORE;
    localparam mmu_pkg::access_e EX = mmu_pkg::ACCESS_EXECUTE;

    logic                      clk;
    logic                      rst_n;
    logic                      ack;
    logic                      satp_mode;
    logic [`MMU_PPN_BITS-1:0]  satp_ppn;
    logic                      flush;
    mmu_pkg::translate_req_t   req;
    mmu_pkg::translate_rsp_t   rsp;
    mmu_pkg::bus_req_t         bus_req;
    mmu_pkg::bus_rsp_t         bus_rsp;

    row_t rows [NUM_ROWS];
    int   mismatch_count;
    int   timeout_count;
    int   bus_reads = 0;

    always #10 clk = ~clk;

    // A read is counted in the cycle it completes.
    always @(negedge clk) begin
        if (rst_n && bus_req.transaction && bus_rsp.done) begin
            bus_reads++;
        end
    end

    mmu_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .ack       (ack),
        .rsp       (rsp),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .satp_mode (satp_mode),
        .satp_ppn  (satp_ppn),
        .flush     (flush)
    );

    page_memory_model #(.SEED(48), .ERROR_PPN(ERROR_PPN)) i_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            mismatch_count++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic put_pte(input logic [21:0] table_ppn, input logic [9:0] index,
                           input logic [21:0] ppn, input logic [7:0] flags);
        i_mem.write_word({table_ppn, index, 2'b00}, {ppn, 2'b00, flags});
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Page tables
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic write_page_tables();
        put_pte(ROOT_PPN, 10'd1, 22'h000101, F_V);
        put_pte(ROOT_PPN, 10'd2, 22'h000C00, F_V | F_R | F_W | F_X | F_A | F_D);  // Megapage.
        put_pte(ROOT_PPN, 10'd3, 22'h000C00, F_R | F_W | F_X | F_A | F_D);
        put_pte(ROOT_PPN, 10'd4, 22'h000C00, F_V | F_W | F_A | F_D);
        put_pte(ROOT_PPN, 10'd5, 22'h000C01, F_V | F_R | F_A);  // Low ppn field set.
        put_pte(ROOT_PPN, 10'd6, ERROR_PPN, F_V);
        put_pte(ROOT_PPN, 10'd7, 22'h000102, F_V);
        put_pte(22'h000101, 10'h010, 22'h012345, F_V | F_R | F_W | F_A | F_D);
        put_pte(22'h000101, 10'h011, 22'h000ABC, F_V | F_R | F_A);
        put_pte(22'h000101, 10'h012, 22'h001111, F_V | F_R | F_W | F_A);
        put_pte(22'h000101, 10'h013, 22'h002222, F_V | F_X | F_A);
        put_pte(22'h000101, 10'h014, 22'h003333, F_V | F_R | F_W | F_X | F_D);
        put_pte(22'h000101, 10'h015, 22'h004444, F_R | F_A);
        put_pte(22'h000102, 10'h020, 22'h000103, F_V);  // Pointer where a leaf must be.
    endtask

    // Each row holds mode, vpn, access, flush first, ppn, pagefault, accessfault and bus reads.
    task automatic load_table();
        rows[0]  = '{1'b0, 20'h00410, LD, 1'b0, 22'h000410, 1'b0, 1'b0, 2'd0};
        rows[1]  = '{1'b0, 20'hFFFFF, ST, 1'b0, 22'h0FFFFF, 1'b0, 1'b0, 2'd0};
        rows[2]  = '{1'b1, 20'h00410, LD, 1'b0, 22'h012345, 1'b0, 1'b0, 2'd2};
        rows[3]  = '{1'b1, 20'h00410, LD, 1'b0, 22'h012345, 1'b0, 1'b0, 2'd0};
        rows[4]  = '{1'b1, 20'h00410, ST, 1'b0, 22'h012345, 1'b0, 1'b0, 2'd0};
        rows[5]  = '{1'b1, 20'h00410, EX, 1'b0, 22'h000000, 1'b1, 1'b0, 2'd0};
        rows[6]  = '{1'b1, 20'h00955, LD, 1'b0, 22'h000D55, 1'b0, 1'b0, 2'd1};
        rows[7]  = '{1'b1, 20'h00955, EX, 1'b0, 22'h000D55, 1'b0, 1'b0, 2'd0};
        rows[8]  = '{1'b1, 20'h00411, ST, 1'b0, 22'h000000, 1'b1, 1'b0, 2'd2};
        rows[9]  = '{1'b1, 20'h00411, LD, 1'b0, 22'h000ABC, 1'b0, 1'b0, 2'd0};
        rows[10] = '{1'b1, 20'h00412, ST, 1'b0, 22'h000000, 1'b1, 1'b0, 2'd2};
        rows[11] = '{1'b1, 20'h00412, LD, 1'b0, 22'h001111, 1'b0, 1'b0, 2'd0};
        rows[12] = '{1'b1, 20'h00413, EX, 1'b0, 22'h002222, 1'b0, 1'b0, 2'd2};
        rows[13] = '{1'b1, 20'h00413, LD, 1'b0, 22'h000000, 1'b1, 1'b0, 2'd0};
        rows[14] = '{1'b1, 20'h00414, LD, 1'b0, 22'h000000, 1'b1, 1'b0, 2'd2};
        rows[15] = '{1'b1, 20'h00414, EX, 1'b0, 22'h000000, 1'b1, 1'b0, 2'd0};
        rows[16] = '{1'b1, 20'h00415, LD, 1'b0, 22'h000000, 1'b1, 1'b0, 2'd2};
        rows[17] = '{1'b1, 20'h00C00, LD, 1'b0, 22'h000000, 1'b1, 1'b0, 2'd1};
        rows[18] = '{1'b1, 20'h01000, LD, 1'b0, 22'h000000, 1'b1, 1'b0, 2'd1};
        rows[19] = '{1'b1, 20'h01400, LD, 1'b0, 22'h000000, 1'b1, 1'b0, 2'd1};
        rows[20] = '{1'b1, 20'h01800, LD, 1'b0, 22'h000000, 1'b0, 1'b1, 2'd2};
        rows[21] = '{1'b1, 20'h01C20, LD, 1'b0, 22'h000000, 1'b1, 1'b0, 2'd2};
        rows[22] = '{1'b1, 20'h00410, LD, 1'b0, 22'h012345, 1'b0, 1'b0, 2'd0};
        rows[23] = '{1'b1, 20'h00410, LD, 1'b1, 22'h012345, 1'b0, 1'b0, 2'd2};
        rows[24] = '{1'b1, 20'h00955, LD, 1'b0, 22'h000D55, 1'b0, 1'b0, 2'd1};
        rows[25] = '{1'b1, 20'h00955, LD, 1'b1, 22'h000D55, 1'b0, 1'b0, 2'd1};
        rows[26] = '{1'b0, 20'h00955, EX, 1'b0, 22'h000955, 1'b0, 1'b0, 2'd0};
        rows[27] = '{1'b1, 20'h00A00, ST, 1'b0, 22'h000E00, 1'b0, 1'b0, 2'd1};
        rows[28] = '{1'b1, 20'h00410, LD, 1'b0, 22'h012345, 1'b0, 1'b0, 2'd2};  // Evicted by 27.
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One request
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic run_row(input int index);
        row_t row;
        int   reads_before;
        int   cycles;
        row = rows[index];
        if (row.flush) begin
            @(posedge clk);
            #2;
            flush = 1'b1;
            @(posedge clk);
            #2;
            flush = 1'b0;
        end
        @(posedge clk);
        #2;
        satp_mode    = row.mode;
        req.request  = 1'b1;
        req.vpn      = row.vpn;
        req.access   = row.access;
        reads_before = bus_reads;
        cycles       = 0;
        @(negedge clk);
        while (!ack && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!ack) begin
            timeout_count++;
            $display("timeout: ack stayed low for %0d cycles in row %0d", ACK_TIMEOUT, index);
            return;
        end
        @(posedge clk);  // The request is taken on this edge.
        #2;
        req.request = 1'b0;
        cycles      = 0;
        @(negedge clk);
        check_value($sformatf("row %0d ack while busy", index), 32'(ack), 32'd0);
        while (!rsp.done && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            check_value($sformatf("row %0d ack while busy", index), 32'(ack), 32'd0);
            cycles++;
        end
        if (!rsp.done) begin
            timeout_count++;
            $display("timeout: no response within %0d cycles in row %0d", DONE_TIMEOUT, index);
            return;
        end
        check_value($sformatf("row %0d ppn", index), 32'(rsp.ppn), 32'(row.ppn));
        check_value($sformatf("row %0d pagefault", index), 32'(rsp.pagefault), 32'(row.pf));
        check_value($sformatf("row %0d accessfault", index), 32'(rsp.accessfault), 32'(row.af));
        check_value($sformatf("row %0d bus reads", index), 32'(bus_reads - reads_before),
                    32'(row.reads));
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        req            = '0;
        satp_mode      = 1'b0;
        satp_ppn       = ROOT_PPN;
        flush          = 1'b0;
        mismatch_count = 0;
        timeout_count  = 0;
        load_table();
        write_page_tables();
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("ack after reset", 32'(ack), 32'd1);
        check_value("done after reset", 32'(rsp.done), 32'd0);
        check_value("bus transaction after reset", 32'(bus_req.transaction), 32'd0);
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
            if (timeout_count != 0) begin
                break;
            end
        end
        $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
